// File: src/dcache_pkg.sv
// Fixed geometry of 2 ways by 16 sets of 16-byte lines on a 16-bit physical byte address
package dcache_pkg;

   localparam int ADDR_W     = 16;
   localparam int WORD_W     = 32;
   localparam int WORD_BYTES = WORD_W / 8;
   localparam int LINE_WORDS = 4;
   localparam int LINE_W     = WORD_W * LINE_WORDS;
   localparam int SETS       = 16;
   localparam int INDEX_W    = $clog2(SETS);
   localparam int WAYS       = 2;
   localparam int OFFSET_W   = $clog2(LINE_W / 8);
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

   // Address fields
   typedef logic [ADDR_W-1:0]             addr_t;
   typedef logic [TAG_W-1:0]              tag_t;
   typedef logic [INDEX_W-1:0]            index_t;
   typedef logic [$clog2(LINE_WORDS)-1:0] word_sel_t;
   typedef logic [ADDR_W-OFFSET_W-1:0]    line_addr_t;

   // Payload and way select
   typedef logic [WORD_W-1:0]             word_t;
   typedef logic [WORD_BYTES-1:0]         wmsk_t;
   typedef logic [LINE_W-1:0]             line_t;
   typedef logic [$clog2(WAYS)-1:0]       way_t;

   // Miss handling states
   typedef enum logic [2:0] {
      MS_IDLE,
      MS_WB_REQ,
      MS_WB_WAIT,
      MS_FILL_REQ,
      MS_FILL_WAIT
   } miss_state_t;

endpackage

// File: src/dcache_ifs.sv
// Both interfaces assume a single stage-1 request and at most one miss in service at a time
`timescale 1ns/1ps

// Stage-1 hit handed to the data array
interface lookup_if
   import dcache_pkg::*;
();

   logic       hit_valid;
   logic       we;
   index_t     index;
   word_sel_t  word_sel;
   wmsk_t      wmsk;
   word_t      wdat;
   way_t       hit_way;

   modport tag  (output hit_valid, we, index, word_sel, wmsk, wdat, hit_way);
   modport data (input  hit_valid, we, index, word_sel, wmsk, wdat, hit_way);

endinterface

// Miss request, victim info and refill traffic
interface refill_if
   import dcache_pkg::*;
();

   logic       fill_en;
   way_t       fill_way;
   line_t      fill_line;
   logic       retry;
   logic       miss;
   index_t     miss_index;
   tag_t       miss_tag;
   tag_t       victim_tag;
   logic       victim_dirty;
   line_t      victim_line;

   modport ctrl (output fill_en, fill_way, fill_line, retry,
                 input  miss, miss_index, miss_tag, victim_tag, victim_dirty, victim_line);
   modport tag  (input  fill_en, fill_way, retry,
                 output miss, miss_index, miss_tag, victim_tag, victim_dirty);
   modport data (input  fill_en, fill_way, fill_line, miss_index,
                 output victim_line);

endinterface

// File: src/tag_stage.sv
// Stage 1 holds one request while stalled; valid and dirty bits reset, tags start unknown
`timescale 1ns/1ps

module tag_stage
   import dcache_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_req,
   input  addr_t   i_addr,
   input  wmsk_t   i_wmsk,
   input  word_t   i_wdat,
   output logic    o_stall,
   lookup_if.tag   lk,
   refill_if.tag   rf
);

   logic                      s1_valid;
   addr_t                     s1_addr;
   wmsk_t                     s1_wmsk;
   word_t                     s1_wdat;
   logic                      pend_q;

   tag_t                      tag_q [WAYS][SETS];
   logic [WAYS-1:0][SETS-1:0] valid_q;
   logic [WAYS-1:0][SETS-1:0] dirty_q;

   tag_t                      s1_tag;
   index_t                    s1_index;
   logic [WAYS-1:0]           hit_vec;
   way_t                      hit_way;
   logic                      lookup_en;
   logic                      hit;

   // Stage-1 valid, held during a stall
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            begin
               s1_valid <= 1'b0;
               pend_q   <= 1'b0;
            end
         else
            begin
               if (!o_stall)
                  s1_valid <= i_req;
               pend_q <= rf.miss;
            end
      end

   always_ff @(posedge clk)
      begin
         if (i_req && !o_stall)
            begin
               s1_addr <= i_addr;
               s1_wmsk <= i_wmsk;
               s1_wdat <= i_wdat;
            end
      end

   assign s1_tag   = s1_addr[ADDR_W-1 -: TAG_W];
   assign s1_index = s1_addr[OFFSET_W +: INDEX_W];

   // Tag compare against both ways
   always_comb
      begin
         hit_way = '0;
         for (int w = 0; w < WAYS; w++)
            begin
               hit_vec[w] = valid_q[w][s1_index] && (tag_q[w][s1_index] == s1_tag);
               if (hit_vec[w])
                  hit_way = way_t'(w);
            end
      end

   // Compare masked while the refill runs, reopened by the retry pulse
   assign lookup_en = s1_valid && (!pend_q || rf.retry);
   assign hit       = lookup_en && (|hit_vec);

   assign rf.miss         = s1_valid && !hit;
   assign rf.miss_index   = s1_index;
   assign rf.miss_tag     = s1_tag;
   assign rf.victim_tag   = tag_q[rf.fill_way][s1_index];
   assign rf.victim_dirty = dirty_q[rf.fill_way][s1_index];
   assign o_stall         = rf.miss;

   assign lk.hit_valid = hit;
   assign lk.we        = |s1_wmsk;
   assign lk.index     = s1_index;
   assign lk.word_sel  = s1_addr[OFFSET_W-1 -: $bits(word_sel_t)];
   assign lk.wmsk      = s1_wmsk;
   assign lk.wdat      = s1_wdat;
   assign lk.hit_way   = hit_way;

   always_ff @(posedge clk)
      begin
         if (rf.fill_en)
            tag_q[rf.fill_way][s1_index] <= s1_tag;
      end

   // New line comes in clean; a store hit marks its way dirty
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            begin
               valid_q <= '0;
               dirty_q <= '0;
            end
         else if (rf.fill_en)
            begin
               valid_q[rf.fill_way][s1_index] <= 1'b1;
               dirty_q[rf.fill_way][s1_index] <= 1'b0;
            end
         else if (hit && lk.we)
            dirty_q[hit_way][s1_index] <= 1'b1;
      end

endmodule

// File: src/data_stage.sv
// Data array has no reset; o_rdata holds the last load word and is valid only with o_rvalid
`timescale 1ns/1ps

module data_stage
   import dcache_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   output logic    o_rvalid,
   output word_t   o_rdata,
   lookup_if.data  lk,
   refill_if.data  rf
);

   line_t  data_q [WAYS][SETS];
   line_t  hit_line;
   line_t  merged_line;
   word_t  hit_word;
   word_t  merged_word;

   // Addressed word and its store merge
   always_comb
      begin
         hit_line    = data_q[lk.hit_way][lk.index];
         hit_word    = hit_line[lk.word_sel*WORD_W +: WORD_W];
         merged_word = hit_word;
         for (int b = 0; b < WORD_BYTES; b++)
            begin
               if (lk.wmsk[b])
                  merged_word[b*8 +: 8] = lk.wdat[b*8 +: 8];
            end
         merged_line = hit_line;
         merged_line[lk.word_sel*WORD_W +: WORD_W] = merged_word;
      end

   // Refill and store hit never coincide since stage 1 is stalled during a fill
   always_ff @(posedge clk)
      begin
         if (rf.fill_en)
            data_q[rf.fill_way][rf.miss_index] <= rf.fill_line;
         else if (lk.hit_valid && lk.we)
            data_q[lk.hit_way][lk.index] <= merged_line;
      end

   // One response per hit, loads and stores alike
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            o_rvalid <= 1'b0;
         else
            o_rvalid <= lk.hit_valid;
      end

   always_ff @(posedge clk)
      begin
         if (lk.hit_valid && !lk.we)
            o_rdata <= hit_word;
      end

   // Line that a dirty eviction writes back
   assign rf.victim_line = data_q[rf.fill_way][rf.miss_index];

endmodule

// File: src/miss_fsm.sv
// One memory request at a time; the response must arrive at least one cycle after the ready edge
`timescale 1ns/1ps

module miss_fsm
   import dcache_pkg::*;
(
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_mem_ready,
   input  logic        i_mem_resp_valid,
   input  line_t       i_mem_rline,
   output logic        o_mem_valid,
   output logic        o_mem_we,
   output line_addr_t  o_mem_line_addr,
   output line_t       o_mem_wline,
   refill_if.ctrl      rf
);

   miss_state_t  state_q;
   miss_state_t  state_nxt;
   way_t         fill_way_q;
   logic         retry_q;
   logic         fill_en;

   always_comb
      begin
         state_nxt = state_q;
         case (state_q)
            MS_IDLE:
               if (rf.miss)
                  state_nxt = rf.victim_dirty ? MS_WB_REQ : MS_FILL_REQ;

            MS_WB_REQ:
               if (i_mem_ready)
                  state_nxt = MS_WB_WAIT;

            // Write ack only
            MS_WB_WAIT:
               if (i_mem_resp_valid)
                  state_nxt = MS_FILL_REQ;

            MS_FILL_REQ:
               if (i_mem_ready)
                  state_nxt = MS_FILL_WAIT;

            // Stays here through the retry cycle
            MS_FILL_WAIT:
               if (retry_q)
                  state_nxt = MS_IDLE;

            default:
               state_nxt = MS_IDLE;
         endcase
      end

   assign fill_en = (state_q == MS_FILL_WAIT) && i_mem_resp_valid;

   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            begin
               state_q    <= MS_IDLE;
               fill_way_q <= '0;
               retry_q    <= 1'b0;
            end
         else
            begin
               state_q <= state_nxt;
               retry_q <= fill_en;
               // Round-robin advances once per replacement
               if (fill_en)
                  fill_way_q <= way_t'(fill_way_q + 1'b1);
            end
      end

   // Payload is stable while valid since stage 1 and the arrays are frozen
   assign o_mem_valid     = (state_q == MS_WB_REQ) || (state_q == MS_FILL_REQ);
   assign o_mem_we        = (state_q == MS_WB_REQ);
   assign o_mem_line_addr = o_mem_we ? {rf.victim_tag, rf.miss_index}
                                     : {rf.miss_tag, rf.miss_index};
   assign o_mem_wline     = rf.victim_line;

   assign rf.fill_en   = fill_en;
   assign rf.fill_way  = fill_way_q;
   assign rf.fill_line = i_mem_rline;
   assign rf.retry     = retry_q;

endmodule

// File: src/dcache_top.sv
// Physical addresses only; no uncached access, flush or invalidate, memory moves whole lines
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
(
   input  logic        clk,
   input  logic        i_rst_n,
   // Core side
   input  logic        i_req,
   input  addr_t       i_addr,
   input  wmsk_t       i_wmsk,
   input  word_t       i_wdat,
   output logic        o_stall,
   output logic        o_rvalid,
   output word_t       o_rdata,
   // Memory side
   output logic        o_mem_valid,
   output logic        o_mem_we,
   output line_addr_t  o_mem_line_addr,
   output line_t       o_mem_wline,
   input  logic        i_mem_ready,
   input  logic        i_mem_resp_valid,
   input  line_t       i_mem_rline
);

   lookup_if u_lookup_if ();
   refill_if u_refill_if ();

   tag_stage u_tag_stage (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_req            (i_req),
      .i_addr           (i_addr),
      .i_wmsk           (i_wmsk),
      .i_wdat           (i_wdat),
      .o_stall          (o_stall),
      .lk               (u_lookup_if.tag),
      .rf               (u_refill_if.tag)
   );

   data_stage u_data_stage (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .o_rvalid         (o_rvalid),
      .o_rdata          (o_rdata),
      .lk               (u_lookup_if.data),
      .rf               (u_refill_if.data)
   );

   miss_fsm u_miss_fsm (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_mem_ready      (i_mem_ready),
      .i_mem_resp_valid (i_mem_resp_valid),
      .i_mem_rline      (i_mem_rline),
      .o_mem_valid      (o_mem_valid),
      .o_mem_we         (o_mem_we),
      .o_mem_line_addr  (o_mem_line_addr),
      .o_mem_wline      (o_mem_wline),
      .rf               (u_refill_if.ctrl)
   );

endmodule

// File: verif/dcache_checker.sv
// Bound into dcache_top; failure flags stay set, so the run must not stop on the first $error
`timescale 1ns/1ps

module dcache_checker
   import dcache_pkg::*;
(
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_mem_valid,
   input  logic        i_mem_we,
   input  line_addr_t  i_mem_line_addr,
   input  line_t       i_mem_wline,
   input  logic        i_mem_ready,
   input  logic        i_mem_resp_valid,
   input  logic        i_rvalid
);

   logic  outstanding;
   bit    stable_err = 1'b0;
   bit    resp_err   = 1'b0;
   bit    rvalid_err = 1'b0;

   // One request in flight between the ready edge and its response
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            outstanding <= 1'b0;
         else if (i_mem_valid && i_mem_ready)
            outstanding <= 1'b1;
         else if (i_mem_resp_valid)
            outstanding <= 1'b0;
      end

   a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_we)
         && $stable(i_mem_line_addr) && $stable(i_mem_wline)))
      else
         begin
            stable_err = 1'b1;
            $error("Memory request dropped or changed before i_mem_ready");
         end

   a_resp_owned: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_resp_valid |-> outstanding)
      else
         begin
            resp_err = 1'b1;
            $error("Memory response with no outstanding request");
         end

   // No load or store completes while a miss waits on the memory port
   a_rvalid_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_valid |-> !i_rvalid)
      else
         begin
            rvalid_err = 1'b1;
            $error("o_rvalid high while a memory request is pending");
         end

endmodule

// File: verif/tb_dcache.sv
// Random traffic over 48 lines (3 tags per set); reads the DUT arrays by hierarchy at the end
`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int NUM_LINES     = 48;
   localparam int NUM_REQ       = 3000;
   localparam int MAX_CYCLES    = 200000;
   localparam int DRAIN_CYCLES  = 2000;
   localparam int SETTLE_CYCLES = 16;
   localparam int RESP_TIMEOUT  = 200;
   localparam int RESET_CYCLES  = 10;

   typedef struct packed {
      logic        is_load;
      logic        must_hit;
      line_addr_t  line;
      word_t       data;
      logic [31:0] acc_cycle;
   } exp_t;

   logic        clk;
   logic        i_rst_n;
   logic        i_req;
   addr_t       i_addr;
   wmsk_t       i_wmsk;
   word_t       i_wdat;
   logic        o_stall;
   logic        o_rvalid;
   word_t       o_rdata;
   logic        o_mem_valid;
   logic        o_mem_we;
   line_addr_t  o_mem_line_addr;
   line_t       o_mem_wline;
   logic        i_mem_ready;
   logic        i_mem_resp_valid;
   line_t       i_mem_rline;

   integer      seed = 32'h7b8b41a2;
   word_t       ref_word [0:(1 << (ADDR_W - 2)) - 1];
   line_t       mem_line [0:(1 << (ADDR_W - OFFSET_W)) - 1];
   bit          fetched  [0:(1 << (ADDR_W - OFFSET_W)) - 1];
   exp_t        exp_q [$];
   int          cycle_cnt;
   int          n_acc;
   int          quiet_cycles;
   int          err_cnt;
   int          guard;
   int          resp_delay;
   logic        resp_pend;
   line_t       resp_line;
   logic        req_must_hit;
   addr_t       last_addr;
   logic        first_mem_done;
   logic        stall_seen;
   logic        mem_valid_seen;
   logic        mem_we_seen;
   line_addr_t  mem_addr_seen;
   line_t       mem_wline_seen;
   logic        i_mem_ready_prev;

   dcache_top dut (.*);

   bind dcache_top dcache_checker u_dcache_checker (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_mem_valid      (o_mem_valid),
      .i_mem_we         (o_mem_we),
      .i_mem_line_addr  (o_mem_line_addr),
      .i_mem_wline      (o_mem_wline),
      .i_mem_ready      (i_mem_ready),
      .i_mem_resp_valid (i_mem_resp_valid),
      .i_rvalid         (o_rvalid)
   );

   initial
      begin
         clk = 1'b0;
         forever #4 clk = ~clk;
      end

   task automatic stop_run();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         begin
            err_cnt++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
         end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         begin
            err_cnt++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
         end
   endtask

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp)
         begin
            err_cnt++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
         end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         begin
            err_cnt++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
         end
   endtask

   task automatic report_failure(input string what);
      err_cnt++;
      $display("%0t %s", $time, what);
      stop_run();
   endtask

   // Memory starts with each word equal to its word address XOR A5A50000
   function automatic word_t init_word(input int word_addr);
      return word_t'(word_addr) ^ 32'hA5A5_0000;
   endfunction

   function automatic line_t ref_line(input line_addr_t la);
      line_t l;
      for (int w = 0; w < LINE_WORDS; w++)
         l[w*WORD_W +: WORD_W] = ref_word[{la, word_sel_t'(w)}];
      return l;
   endfunction

   task automatic drive_request(input bit gen, input bit taken);
      logic [31:0] rnd;
      int          line_no;
      if (taken || !i_req)
         begin
            i_req  = 1'b0;
            i_wmsk = '0;
            rnd    = $random(seed);
            if (gen && rnd[2:0] != 3'd0)
               begin
                  i_req        = 1'b1;
                  req_must_hit = 1'b0;
                  // Repeat load of the last address must hit
                  if (n_acc > 0 && rnd[4:3] == 2'd0)
                     begin
                        i_addr       = last_addr;
                        req_must_hit = 1'b1;
                     end
                  else
                     begin
                        line_no = int'(rnd[31:16]) % NUM_LINES;
                        i_addr  = addr_t'(line_no * (LINE_W / 8) + int'(rnd[6:5]) * WORD_BYTES);
                        if (rnd[7])
                           begin
                              i_wmsk = rnd[11:8];
                              if (i_wmsk == '0)
                                 i_wmsk = '1;
                              i_wdat = $random(seed);
                           end
                     end
               end
         end
   endtask

   task automatic step_cycle(input bit gen);
      exp_t                e;
      logic [ADDR_W-3:0]   wa;
      logic                taken;
      @(posedge clk);
      #1;
      cycle_cnt++;
      taken            = 1'b0;
      i_mem_ready      = 1'b0;
      i_mem_resp_valid = 1'b0;

      // Request accepted at this edge
      if (i_req && !stall_seen)
         begin
            wa = i_addr[ADDR_W-1:2];
            for (int b = 0; b < WORD_BYTES; b++)
               begin
                  if (i_wmsk[b])
                     ref_word[wa][b*8 +: 8] = i_wdat[b*8 +: 8];
               end
            e.is_load   = (i_wmsk == '0);
            e.must_hit  = req_must_hit;
            e.line      = i_addr[ADDR_W-1:OFFSET_W];
            e.data      = ref_word[wa];
            e.acc_cycle = cycle_cnt;
            exp_q.push_back(e);
            n_acc++;
            last_addr = i_addr;
            taken     = 1'b1;
         end

      // Memory handshake at this edge
      if (mem_valid_seen && i_mem_ready_prev)
         begin
            if (!first_mem_done)
               check_bit("o_mem_we", mem_we_seen, 1'b0);
            first_mem_done = 1'b1;
            if (mem_we_seen)
               begin
                  if (!fetched[mem_addr_seen])
                     report_failure($sformatf("Write-back of line %h that was never read",
                                              mem_addr_seen));
                  check_line("o_mem_wline", mem_wline_seen, ref_line(mem_addr_seen));
                  mem_line[mem_addr_seen] = mem_wline_seen;
                  resp_line = '0;
               end
            else
               begin
                  fetched[mem_addr_seen] = 1'b1;
                  resp_line = mem_line[mem_addr_seen];
               end
            resp_pend  = 1'b1;
            resp_delay = $unsigned($random(seed)) % 3;
         end

      if (dut.u_dcache_checker.stable_err || dut.u_dcache_checker.resp_err
          || dut.u_dcache_checker.rvalid_err)
         report_failure("A bound assertion on dcache_top failed");

      if (o_rvalid)
         begin
            if (exp_q.size() == 0)
               report_failure("o_rvalid with no accepted request outstanding");
            e = exp_q.pop_front();
            quiet_cycles = 0;
            if (!fetched[e.line])
               report_failure($sformatf("o_rvalid for line %h before any memory read", e.line));
            if (e.is_load)
               check_word("o_rdata", o_rdata, e.data);
            if (e.must_hit)
               check_count("o_rvalid edges after repeat load",
                           cycle_cnt - int'(e.acc_cycle) + 1, 2);
         end
      else if (exp_q.size() != 0)
         begin
            quiet_cycles++;
            if (quiet_cycles > RESP_TIMEOUT)
               report_failure($sformatf("No o_rvalid within %0d cycles", RESP_TIMEOUT));
         end

      stall_seen     = o_stall;
      mem_valid_seen = o_mem_valid;
      mem_we_seen    = o_mem_we;
      mem_addr_seen  = o_mem_line_addr;
      mem_wline_seen = o_mem_wline;

      // Memory side with random ready and response delays
      if (resp_pend)
         begin
            if (resp_delay == 0)
               begin
                  i_mem_resp_valid = 1'b1;
                  i_mem_rline      = resp_line;
                  resp_pend        = 1'b0;
               end
            else
               resp_delay--;
         end
      else if (o_mem_valid)
         i_mem_ready = ($random(seed) & 1) != 0;
      i_mem_ready_prev = i_mem_ready;

      drive_request(gen, taken);
   endtask

   task automatic check_final_state();
      line_addr_t  la;
      index_t      idx;
      logic        held;
      logic        dirty;
      way_t        hw;
      for (int l = 0; l < NUM_LINES; l++)
         begin
            la    = line_addr_t'(l);
            idx   = la[INDEX_W-1:0];
            held  = 1'b0;
            dirty = 1'b0;
            hw    = '0;
            for (int w = 0; w < WAYS; w++)
               begin
                  if (dut.u_tag_stage.valid_q[w][idx]
                      && dut.u_tag_stage.tag_q[w][idx] == la[INDEX_W +: TAG_W])
                     begin
                        held  = 1'b1;
                        hw    = way_t'(w);
                        dirty = dut.u_tag_stage.dirty_q[w][idx];
                     end
               end
            if (held)
               check_line("cached line", dut.u_data_stage.data_q[hw][idx], ref_line(la));
            if (!held || !dirty)
               check_line("memory line", mem_line[la], ref_line(la));
         end
   endtask

   initial
      begin
         i_rst_n          = 1'b0;
         i_req            = 1'b0;
         i_addr           = '0;
         i_wmsk           = '0;
         i_wdat           = '0;
         i_mem_ready      = 1'b0;
         i_mem_resp_valid = 1'b0;
         i_mem_rline      = '0;
         i_mem_ready_prev = 1'b0;
         resp_pend        = 1'b0;
         resp_line        = '0;
         req_must_hit     = 1'b0;
         first_mem_done   = 1'b0;
         for (int wa = 0; wa < (1 << (ADDR_W - 2)); wa++)
            ref_word[wa] = init_word(wa);
         for (int la = 0; la < (1 << (ADDR_W - OFFSET_W)); la++)
            begin
               fetched[la] = 1'b0;
               for (int w = 0; w < LINE_WORDS; w++)
                  mem_line[la][w*WORD_W +: WORD_W] = init_word(la * LINE_WORDS + w);
            end

         repeat (RESET_CYCLES) @(posedge clk);
         #1;
         i_rst_n = 1'b1;
         check_bit("o_stall", o_stall, 1'b0);
         check_bit("o_rvalid", o_rvalid, 1'b0);
         check_bit("o_mem_valid", o_mem_valid, 1'b0);
         stall_seen     = o_stall;
         mem_valid_seen = o_mem_valid;

         for (guard = 0; guard < MAX_CYCLES && n_acc < NUM_REQ; guard++)
            step_cycle(1'b1);
         if (n_acc < NUM_REQ)
            report_failure($sformatf("Only %0d requests accepted in %0d cycles", n_acc,
                                     MAX_CYCLES));

         // Drain the pipeline and any refill still running
         for (guard = 0; guard < DRAIN_CYCLES && (exp_q.size() != 0 || i_req); guard++)
            step_cycle(1'b0);
         if (exp_q.size() != 0 || i_req)
            report_failure("Requests still open after the drain period");

         // Idle window where any further o_rvalid has no request behind it
         for (guard = 0; guard < SETTLE_CYCLES; guard++)
            step_cycle(1'b0);

         check_final_state();

         if (err_cnt == 0)
            begin
               $display("No errors");
               $finish;
            end
         else
            stop_run();
      end

endmodule

// File: all.f
src/dcache_pkg.sv
src/dcache_ifs.sv
src/tag_stage.sv
src/data_stage.sv
src/miss_fsm.sv
src/dcache_top.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
      -Mdir obj_dir -f all.f; then
   echo "Verilator build failed"
   exit 1
fi

# The bound checker raises flags that the testbench polls, so $error must not stop the run
sim_out=$(./obj_dir/Vtb_dcache +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "No errors"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
